// File: logic/snake_grid_pkg.sv
package snake_grid_pkg;

    // Playfield size in cells
    localparam int grid_w = 16;
    localparam int grid_h = 12;
    localparam int cell_count = grid_w * grid_h;

    localparam int coord_w = 4;     // Bits for one coordinate
    localparam int cell_idx_w = 8;  // Flat cell index, y * grid_w + x

    // What a cell can hold, in falling priority border, head, body, apple
    typedef enum logic [2:0] {
        blank      = 3'd0,
        snake_head = 3'd1,
        snake_body = 3'd2,
        apple_c    = 3'd3,
        border_c   = 3'd4
    } obj_code_t;

    // One change for the drawing engine, 11 bits
    typedef struct packed {
        obj_code_t          obj_code;
        logic [coord_w-1:0] y;
        logic [coord_w-1:0] x;
    } update_rec_t;

    localparam int fifo_depth = 64;
    localparam int fifo_ptr_w = 6;
    localparam int fifo_count_w = 7;  // Must hold fifo_depth itself

endpackage

// File: logic/snake_bus_pkg.sv
package snake_bus_pkg;

    localparam int apb_addr_w = 8;
    localparam int apb_data_w = 32;

    // Register map
    localparam logic [apb_addr_w-1:0] addr_ctrl   = 8'h00;
    localparam logic [apb_addr_w-1:0] addr_head   = 8'h04;
    localparam logic [apb_addr_w-1:0] addr_apple  = 8'h08;
    localparam logic [apb_addr_w-1:0] addr_body   = 8'h0C;  // Write only
    localparam logic [apb_addr_w-1:0] addr_status = 8'h10;
    localparam logic [apb_addr_w-1:0] addr_update = 8'h14;  // Read pops the queue

    localparam int ctrl_scan_en = 0;

    // Position layout shared by head, apple and body
    localparam int pos_x_lsb = 0;
    localparam int pos_y_lsb = 4;
    localparam int body_set_bit = 8;

    // Status layout
    localparam int stat_count_lsb = 0;
    localparam int stat_frame_lsb = 16;
    localparam int frame_cnt_w = 8;

    localparam int upd_valid_bit = 31;

endpackage

// File: logic/scene_if.sv
`timescale 1ns/1ps

// Scene as written by the host, seen by the classifier
interface scene_if
    import snake_grid_pkg::*;
();

    logic [coord_w-1:0]    head_x;
    logic [coord_w-1:0]    head_y;
    logic [coord_w-1:0]    apple_x;
    logic [coord_w-1:0]    apple_y;
    logic [cell_count-1:0] body;  // Bit y * grid_w + x

    modport regs (
        output head_x,
        output head_y,
        output apple_x,
        output apple_y,
        output body
    );

    modport classifier (
        input head_x,
        input head_y,
        input apple_x,
        input apple_y,
        input body
    );

endinterface

// File: logic/update_queue_if.sv
`timescale 1ns/1ps

// Drain side of the update queue
interface update_queue_if
    import snake_grid_pkg::*;
();

    logic                    pop;    // One-cycle pulse, only while not empty
    update_rec_t             rec;    // Head of queue, valid when not empty
    logic                    empty;
    logic [fifo_count_w-1:0] count;

    modport regs (
        output pop,
        input  rec,
        input  empty,
        input  count
    );

    modport fifo (
        input  pop,
        output rec,
        output empty,
        output count
    );

endinterface

// File: logic/cell_classifier.sv
`timescale 1ns/1ps

module cell_classifier
    import snake_grid_pkg::*;
(
    input  logic [3:0]         x,
    input  logic [3:0]         y,
    scene_if.classifier        scene,
    output logic               border,
    output logic               head,
    output logic               body,
    output logic               apple
);

    logic [cell_idx_w-1:0] cell_idx;

    // Flat index into the body bitmap
    assign cell_idx = cell_idx_w'(y) * cell_idx_w'(grid_w) + cell_idx_w'(x);

    // The outer ring of the grid is always wall
    assign border = (x == '0) || (x == coord_w'(grid_w - 1)) ||
                    (y == '0) || (y == coord_w'(grid_h - 1));

    assign head  = (x == scene.head_x) && (y == scene.head_y);
    assign apple = (x == scene.apple_x) && (y == scene.apple_y);

    // The scanner never leaves the grid, so the index stays below cell_count
    assign body = scene.body[cell_idx];

endmodule

// File: logic/frame_tracker.sv
`timescale 1ns/1ps

module frame_tracker
    import snake_grid_pkg::*;
(
    input  logic      clk,
    input  logic      nrst,
    input  logic      enable,
    input  logic      border,
    input  logic      head,
    input  logic      body,
    input  logic      apple,
    output obj_code_t obj_code,
    output logic [3:0] x,
    output logic [3:0] y,
    output logic      diff,
    output logic      frame_wrap
);

    // Last code reported for every cell
    obj_code_t frame [grid_h][grid_w];

    logic [coord_w-1:0] cur_x;
    logic [coord_w-1:0] cur_y;
    obj_code_t          new_code;
    obj_code_t          stored_code;
    logic               last_col;
    logic               last_row;

    assign last_col = (cur_x == coord_w'(grid_w - 1));
    assign last_row = (cur_y == coord_w'(grid_h - 1));

    assign stored_code = frame[cur_y][cur_x];

    // Resolve the flags by priority
    always_comb begin
        if (border) begin
            new_code = border_c;
        end else if (head) begin
            new_code = snake_head;
        end else if (body) begin
            new_code = snake_body;
        end else if (apple) begin
            new_code = apple_c;
        end else begin
            new_code = blank;
        end
    end

    assign obj_code = new_code;

    // Only a cell that is actually stepped over counts as a change
    assign diff = enable && (new_code != stored_code);

    assign frame_wrap = enable && last_col && last_row;  // Step from the last cell back to (0,0)

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            frame <= '{default: blank};
        end else if (enable) begin
            frame[cur_y][cur_x] <= new_code;
        end
    end

    // Scan position, x runs fastest
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            cur_x <= '0;
            cur_y <= '0;
        end else if (enable) begin
            if (last_col) begin
                cur_x <= '0;
                cur_y <= last_row ? '0 : cur_y + 1'b1;
            end else begin
                cur_x <= cur_x + 1'b1;
            end
        end
    end

    assign x = cur_x;
    assign y = cur_y;

endmodule

// File: logic/update_fifo.sv
`timescale 1ns/1ps

module update_fifo
    import snake_grid_pkg::*;
(
    input  logic        clk,
    input  logic        nrst,
    input  logic        push,
    input  update_rec_t push_rec,
    output logic        full,
    update_queue_if.fifo q
);

    update_rec_t mem [fifo_depth];

    logic [fifo_ptr_w-1:0]   wr_ptr;
    logic [fifo_ptr_w-1:0]   rd_ptr;
    logic [fifo_count_w-1:0] count;
    logic                    empty;
    logic                    do_pop;

    assign empty = (count == '0);
    assign full  = (count == fifo_count_w'(fifo_depth));

    // A stray pop on an empty queue is ignored
    assign do_pop = q.pop && !empty;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_rec;
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither leave the level as is
            endcase
        end
    end

    assign q.rec   = mem[rd_ptr];
    assign q.empty = empty;
    assign q.count = count;

endmodule

// File: logic/apb_game_regs.sv
`timescale 1ns/1ps

module apb_game_regs
    import snake_grid_pkg::*;
    import snake_bus_pkg::*;
(
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [7:0]            paddr,
    input  logic [31:0]           pwdata,
    input  logic                  frame_wrap,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic                  scan_en,
    output logic                  irq,
    scene_if.regs                 scene,
    update_queue_if.regs          q
);

    logic                   access;
    logic                   wr_en;
    logic                   rd_en;
    logic                   addr_ok;
    logic [apb_data_w-1:0]  rd_data;
    logic [frame_cnt_w-1:0] frame_cnt;
    logic [coord_w-1:0]     wr_x;
    logic [coord_w-1:0]     wr_y;
    logic [cell_idx_w-1:0]  body_idx;

    assign access = psel && penable;
    assign wr_en  = access && pwrite;
    assign rd_en  = access && !pwrite;

    assign wr_x = pwdata[pos_x_lsb +: coord_w];
    assign wr_y = pwdata[pos_y_lsb +: coord_w];
    assign body_idx = cell_idx_w'(wr_y) * cell_idx_w'(grid_w) + cell_idx_w'(wr_x);

    // Writes land on the edge that closes the access phase
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            scan_en       <= 1'b0;
            scene.head_x  <= '0;
            scene.head_y  <= '0;
            scene.apple_x <= '0;
            scene.apple_y <= '0;
            scene.body    <= '0;
        end else if (wr_en) begin
            case (paddr)
                addr_ctrl: scan_en <= pwdata[ctrl_scan_en];
                addr_head: begin
                    scene.head_x <= wr_x;
                    scene.head_y <= wr_y;
                end
                addr_apple: begin
                    scene.apple_x <= wr_x;
                    scene.apple_y <= wr_y;
                end
                addr_body: begin
                    // Rows past the bottom of the grid are dropped
                    if (body_idx < cell_idx_w'(cell_count)) begin
                        scene.body[body_idx] <= pwdata[body_set_bit];
                    end
                end
                default: ;  // Status, update and unmapped addresses hold no writable state
            endcase
        end
    end

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            frame_cnt <= '0;
        end else if (frame_wrap) begin
            frame_cnt <= frame_cnt + 1'b1;  // Wraps modulo 256
        end
    end

    // Read mux, also tells which addresses are mapped
    always_comb begin
        rd_data = '0;
        addr_ok = 1'b1;
        case (paddr)
            addr_ctrl: rd_data[ctrl_scan_en] = scan_en;
            addr_head: begin
                rd_data[pos_x_lsb +: coord_w] = scene.head_x;
                rd_data[pos_y_lsb +: coord_w] = scene.head_y;
            end
            addr_apple: begin
                rd_data[pos_x_lsb +: coord_w] = scene.apple_x;
                rd_data[pos_y_lsb +: coord_w] = scene.apple_y;
            end
            addr_body: ;
            addr_status: begin
                rd_data[stat_count_lsb +: fifo_count_w] = q.count;
                rd_data[stat_frame_lsb +: frame_cnt_w]  = frame_cnt;
            end
            addr_update: begin
                // An empty queue reads back as all zero
                if (!q.empty) begin
                    rd_data[upd_valid_bit]              = 1'b1;
                    rd_data[$bits(update_rec_t)-1:0]    = q.rec;
                end
            end
            default: addr_ok = 1'b0;
        endcase
    end

    assign prdata  = rd_en ? rd_data : '0;
    assign pready  = 1'b1;  // Zero wait states
    assign pslverr = access && (!addr_ok || (!pwrite && (paddr == addr_body)));

    // The record on q.rec in this cycle is the one returned on prdata
    assign q.pop = rd_en && (paddr == addr_update) && !q.empty;

    assign irq = !q.empty;

endmodule

// File: logic/snake_display_top.sv
`timescale 1ns/1ps

module snake_display_top
    import snake_grid_pkg::*;
    import snake_bus_pkg::*;
(
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [apb_addr_w-1:0] paddr,
    input  logic [apb_data_w-1:0] pwdata,
    output logic [apb_data_w-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic                  irq
);

    scene_if        scene_bus ();
    update_queue_if queue_bus ();

    logic               scan_en;
    logic               enable;
    logic               full;
    logic               frame_wrap;
    logic [coord_w-1:0] cell_x;
    logic [coord_w-1:0] cell_y;
    logic               border;
    logic               head;
    logic               body;
    logic               apple;
    logic               diff;
    obj_code_t          obj_code;
    update_rec_t        push_rec;

    // Scan stalls on a full queue so no change is lost
    assign enable = scan_en && !full;

    assign push_rec = '{obj_code: obj_code, y: cell_y, x: cell_x};

    apb_game_regs regs0 (
        .clk        (clk),
        .nrst       (nrst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .frame_wrap (frame_wrap),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .scan_en    (scan_en),
        .irq        (irq),
        .scene      (scene_bus.regs),
        .q          (queue_bus.regs)
    );

    cell_classifier classifier0 (
        .x      (cell_x),
        .y      (cell_y),
        .scene  (scene_bus.classifier),
        .border (border),
        .head   (head),
        .body   (body),
        .apple  (apple)
    );

    frame_tracker tracker0 (
        .clk        (clk),
        .nrst       (nrst),
        .enable     (enable),
        .border     (border),
        .head       (head),
        .body       (body),
        .apple      (apple),
        .obj_code   (obj_code),
        .x          (cell_x),
        .y          (cell_y),
        .diff       (diff),
        .frame_wrap (frame_wrap)
    );

    update_fifo fifo0 (
        .clk      (clk),
        .nrst     (nrst),
        .push     (diff),  // diff is only high on an enabled step
        .push_rec (push_rec),
        .full     (full),
        .q        (queue_bus.fifo)
    );

endmodule

// File: test/snake_display_assert.sv
`timescale 1ns/1ps

module snake_display_assert (
    input logic clk,
    input logic nrst,
    input logic push,
    input logic full,
    input logic pop,
    input logic empty,
    input logic pready,
    input logic irq
);

    int fail_count = 0;  // Read by the testbench at the end of the run

    no_push_when_full: assert property (@(posedge clk) disable iff (!nrst) push |-> !full)
        else begin
            fail_count++;
            $error("A record was pushed into a full update queue");
        end

    no_pop_when_empty: assert property (@(posedge clk) disable iff (!nrst) pop |-> !empty)
        else begin
            fail_count++;
            $error("The update queue was popped while empty");
        end

    ready_high: assert property (@(posedge clk) disable iff (!nrst) pready)
        else begin
            fail_count++;
            $error("pready went low on a zero wait state bus");
        end

    irq_follows_queue: assert property (@(posedge clk) disable iff (!nrst) irq == !empty)
        else begin
            fail_count++;
            $error("irq does not match the queue holding records");
        end

endmodule

// The FIFO and the register block meet in the top level
bind snake_display_top snake_display_assert rules0 (
    .clk    (clk),
    .nrst   (nrst),
    .push   (diff),
    .full   (full),
    .pop    (queue_bus.pop),
    .empty  (queue_bus.empty),
    .pready (pready),
    .irq    (irq)
);

// File: test/snake_display_checker.sv
`timescale 1ns/1ps

// Shadow model of scene, stored frame and queue; predicts every update record
module snake_display_checker
    import snake_grid_pkg::*;
    import snake_bus_pkg::*;
(
    input logic        clk,
    input logic        nrst,
    input logic        psel,
    input logic        penable,
    input logic        pwrite,
    input logic [7:0]  paddr,
    input logic [31:0] pwdata,
    input logic [31:0] prdata,
    input logic        pslverr,
    input logic        irq
);

    string                 test_name = "reset";
    int                    check_count = 0;
    int                    error_count = 0;
    int                    popped = 0;  // Valid records read since the last count check
    int                    peak = 0;    // Highest queue level seen in this test
    logic [2:0]            shadow_frame [cell_count];
    logic [cell_count-1:0] body_map;
    logic [3:0]            head_x;
    logic [3:0]            head_y;
    logic [3:0]            apple_x;
    logic [3:0]            apple_y;
    logic                  scan_on;
    int                    scan_pos;
    logic [7:0]            frames;
    logic [10:0]           expected_q [$];  // Oldest record first
    logic                  pend_valid = 1'b0;
    logic [31:0]           pend_data;
    logic                  pend_err;

    // Border wins over head, head over body, body over apple
    function automatic logic [2:0] predict_code(input int pos);
        int cx;
        int cy;
        cx = pos % grid_w;
        cy = pos / grid_w;
        if (cx == 0 || cx == grid_w - 1 || cy == 0 || cy == grid_h - 1) return border_c;
        if (cx == head_x && cy == head_y) return snake_head;
        if (body_map[pos]) return snake_body;
        if (cx == apple_x && cy == apple_y) return apple_c;
        return blank;
    endfunction

    task automatic compare_value(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("error %s: %s expected %h, actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        popped = 0;
        peak = 0;
    endtask

    // Expectation for the next bus access from the stimulus table
    task automatic note_expect(input logic [31:0] data, input logic err);
        pend_data = data;
        pend_err = err;
        pend_valid = 1'b1;
    endtask

    task automatic check_records(input int expected);
        compare_value("record count", expected, popped);
        popped = 0;
    endtask

    task automatic check_peak(input int expected);
        compare_value("peak queue count", expected, peak);
    endtask

    // Sampled mid cycle, the model state here matches the DUT before the next edge
    always @(negedge clk) begin : model_step
        logic        access;
        logic        pop;
        logic [2:0]  code;
        logic [31:0] rec_word;
        if (!nrst) begin
            foreach (shadow_frame[i]) shadow_frame[i] = blank;
            body_map = '0;
            head_x = '0;
            head_y = '0;
            apple_x = '0;
            apple_y = '0;
            scan_on = 1'b0;
            scan_pos = 0;
            frames = '0;
            expected_q.delete();
        end else begin
            access = psel && penable;
            compare_value("irq", {31'b0, expected_q.size() != 0}, {31'b0, irq});
            if (access) begin
                compare_value("pslverr", {31'b0, pend_valid && pend_err}, {31'b0, pslverr});
                if (pend_valid && !pwrite) compare_value("read data", pend_data, prdata);
                pend_valid = 1'b0;
            end
            if (access && !pwrite && paddr == addr_update) begin
                rec_word = '0;
                if (expected_q.size() != 0) rec_word = {1'b1, 20'h0, expected_q[0]};
                compare_value("update record", rec_word, prdata);
            end
            if (access && !pwrite && paddr == addr_status) begin
                compare_value("status", {8'h0, frames, 9'h0, 7'(expected_q.size())}, prdata);
            end
            pop = access && !pwrite && paddr == addr_update && expected_q.size() != 0;
            // One cell per cycle unless the queue is full
            if (scan_on && expected_q.size() < fifo_depth) begin
                code = predict_code(scan_pos);
                if (code != shadow_frame[scan_pos]) begin
                    expected_q.push_back({code, 4'(scan_pos / grid_w), 4'(scan_pos % grid_w)});
                    shadow_frame[scan_pos] = code;
                end
                if (scan_pos == cell_count - 1) begin
                    scan_pos = 0;
                    frames++;
                end else begin
                    scan_pos++;
                end
            end
            if (pop) begin
                void'(expected_q.pop_front());
                popped++;
            end
            if (expected_q.size() > peak) peak = expected_q.size();
            if (access && pwrite) begin
                case (paddr)
                    addr_ctrl: scan_on = pwdata[ctrl_scan_en];
                    addr_head: begin
                        head_x = pwdata[3:0];
                        head_y = pwdata[7:4];
                    end
                    addr_apple: begin
                        apple_x = pwdata[3:0];
                        apple_y = pwdata[7:4];
                    end
                    addr_body: begin
                        if (pwdata[7:4] < grid_h) begin
                            body_map[pwdata[7:4] * grid_w + pwdata[3:0]] = pwdata[8];
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

// File: test/tb_snake_display.sv
`timescale 1ns/1ps

module tb_snake_display
    import snake_grid_pkg::*;
    import snake_bus_pkg::*;
();

    localparam int poll_limit  = 2000;
    localparam int drain_limit = 200;
    localparam int ready_limit = 16;

    typedef enum logic [1:0] {op_write, op_read, op_run} op_t;

    // For a run, data holds the number of records and fill asks for a full queue
    typedef struct packed {
        op_t         op;
        logic [7:0]  addr;
        logic [31:0] data;
        logic        err;
        logic        fill;
    } step_t;

    logic        clk = 1'b0;
    logic        nrst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        irq;
    logic        timed_out;
    int          seed;
    step_t       steps [$];
    string       step_name [$];

    always #50 clk = ~clk;

    snake_display_top dut0 (
        .clk     (clk),
        .nrst    (nrst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .irq     (irq)
    );

    snake_display_checker chk0 (
        .clk     (clk),
        .nrst    (nrst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pslverr (pslverr),
        .irq     (irq)
    );

    function automatic void add_step(input string name, input op_t op, input logic [7:0] addr,
                                     input logic [31:0] data, input logic err, input logic fill);
        steps.push_back('{op, addr, data, err, fill});
        step_name.push_back(name);
    endfunction

    // One APB transfer, starting 10 ns after a rising edge
    task automatic apb_access(input logic write, input logic [7:0] addr,
                              input logic [31:0] data, output logic [31:0] rdata);
        int waits;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = write;
        paddr = addr;
        pwdata = data;
        @(posedge clk);
        #10 penable = 1'b1;
        waits = 0;
        @(negedge clk);
        while (!pready && waits < ready_limit) begin
            @(negedge clk);
            waits++;
        end
        if (!pready) begin
            $display("timeout: pready stayed low at address %h", addr);
            timed_out = 1'b1;
        end
        rdata = prdata;
        @(posedge clk);
        #10 psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic drain_queue();
        logic [31:0] rd;
        int          reads;
        rd = 32'h8000_0000;
        reads = 0;
        while (rd[upd_valid_bit] && !timed_out) begin
            if (reads == drain_limit) begin
                $display("timeout: update queue did not run empty");
                timed_out = 1'b1;
            end else begin
                apb_access(1'b0, addr_update, 32'h0, rd);
                reads++;
            end
        end
    endtask

    // Enable, wait for two frame wraps, disable, then collect what is left
    task automatic run_scan(input int expected, input logic expect_fill);
        logic [31:0] rd;
        logic [7:0]  start_frames;
        logic [7:0]  advanced;
        int          polls;
        apb_access(1'b1, addr_ctrl, 32'h1, rd);
        apb_access(1'b0, addr_status, 32'h0, rd);
        start_frames = rd[stat_frame_lsb +: frame_cnt_w];
        advanced = 8'h0;
        polls = 0;
        while (advanced < 2 && !timed_out) begin
            if (polls == poll_limit) begin
                $display("timeout: scan did not complete two frames");
                timed_out = 1'b1;
            end else begin
                if (rd[6:0] == fifo_depth) drain_queue();  // Scan is stalled on a full queue
                apb_access(1'b0, addr_status, 32'h0, rd);
                advanced = rd[stat_frame_lsb +: frame_cnt_w] - start_frames;
                polls++;
            end
        end
        if (!timed_out) begin
            apb_access(1'b1, addr_ctrl, 32'h0, rd);
            drain_queue();
            chk0.check_records(expected);
            if (expect_fill) chk0.check_peak(fifo_depth);
        end
    endtask

    initial begin
        string       current;
        logic [31:0] rd;
        logic [3:0]  rx;
        logic [3:0]  ry;
        bit          seen [cell_count];
        int          fresh;
        int          total_errors;
        nrst = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        timed_out = 1'b0;
        seed = 32'h211e_5d80;

        add_step("reset", op_read, addr_status, 32'h0, 1'b0, 1'b0);
        add_step("reset", op_read, addr_update, 32'h0, 1'b0, 1'b0);
        add_step("reset", op_read, addr_ctrl, 32'h0, 1'b0, 1'b0);
        add_step("empty_scene", op_run, 8'h0, 32'd52, 1'b0, 1'b0);  // Only the border ring
        add_step("empty_scene", op_run, 8'h0, 32'd0, 1'b0, 1'b0);
        add_step("priority", op_write, addr_body, 32'h155, 1'b0, 1'b0);
        add_step("priority", op_write, addr_head, 32'h55, 1'b0, 1'b0);   // Head on a body cell
        add_step("priority", op_write, addr_apple, 32'h30, 1'b0, 1'b0);  // Apple on the border
        add_step("priority", op_run, 8'h0, 32'd1, 1'b0, 1'b0);
        add_step("priority", op_write, addr_apple, 32'h68, 1'b0, 1'b0);
        add_step("priority", op_run, 8'h0, 32'd1, 1'b0, 1'b0);
        add_step("priority", op_write, addr_head, 32'h0F, 1'b0, 1'b0);   // Body shows again at 5,5
        add_step("priority", op_run, 8'h0, 32'd1, 1'b0, 1'b0);
        add_step("move_head", op_write, addr_head, 32'h33, 1'b0, 1'b0);
        add_step("move_head", op_run, 8'h0, 32'd1, 1'b0, 1'b0);
        add_step("move_head", op_write, addr_head, 32'h34, 1'b0, 1'b0);
        add_step("move_head", op_run, 8'h0, 32'd2, 1'b0, 1'b0);
        add_step("move_head", op_read, addr_head, 32'h34, 1'b0, 1'b0);

        // Head at 4,3 and body at 5,5 give no new record
        seen[3 * grid_w + 4] = 1'b1;
        seen[5 * grid_w + 5] = 1'b1;
        fresh = 0;
        for (int i = 0; i < 110; i++) begin
            rx = 4'(1 + {$random(seed)} % (grid_w - 2));
            ry = 4'(1 + {$random(seed)} % (grid_h - 2));
            if (!seen[ry * grid_w + rx]) begin
                seen[ry * grid_w + rx] = 1'b1;
                fresh++;
            end
            add_step("back_pressure", op_write, addr_body, {23'h0, 1'b1, ry, rx}, 1'b0, 1'b0);
        end
        add_step("back_pressure", op_run, 8'h0, fresh, 1'b0, 1'b1);

        add_step("bus_errors", op_read, addr_body, 32'h0, 1'b1, 1'b0);
        add_step("bus_errors", op_read, 8'h18, 32'h0, 1'b1, 1'b0);
        add_step("bus_errors", op_write, 8'h24, 32'h1, 1'b1, 1'b0);
        add_step("bus_errors", op_write, 8'h44, 32'h99, 1'b1, 1'b0);
        add_step("bus_errors", op_read, addr_ctrl, 32'h0, 1'b0, 1'b0);
        add_step("bus_errors", op_read, addr_head, 32'h34, 1'b0, 1'b0);
        add_step("bus_errors", op_read, addr_apple, 32'h68, 1'b0, 1'b0);
        add_step("bus_errors", op_run, 8'h0, 32'd0, 1'b0, 1'b0);

        repeat (4) @(posedge clk);
        #10 nrst = 1'b1;

        for (int i = 0; i < steps.size() && !timed_out; i++) begin
            if (step_name[i] != current) begin
                current = step_name[i];
                chk0.start_test(current);
            end
            case (steps[i].op)
                op_write: begin
                    chk0.note_expect(steps[i].data, steps[i].err);
                    apb_access(1'b1, steps[i].addr, steps[i].data, rd);
                end
                op_read: begin
                    chk0.note_expect(steps[i].data, steps[i].err);
                    apb_access(1'b0, steps[i].addr, 32'h0, rd);
                end
                default: run_scan(steps[i].data, steps[i].fill);
            endcase
        end

        total_errors = chk0.error_count + dut0.rules0.fail_count + int'(timed_out);
        $display("checks %0d, errors %0d, assertion failures %0d, timeouts %0d",
                 chk0.check_count, chk0.error_count, dut0.rules0.fail_count,
                 int'(timed_out));
        if (total_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: filelist.f
logic/snake_grid_pkg.sv
logic/snake_bus_pkg.sv
logic/scene_if.sv
logic/update_queue_if.sv
logic/cell_classifier.sv
logic/frame_tracker.sv
logic/update_fifo.sv
logic/apb_game_regs.sv
logic/snake_display_top.sv
test/snake_display_assert.sv
test/snake_display_checker.sv
test/tb_snake_display.sv

// File: Bender.yml
package:
  name: snake_display

sources:
  - logic/snake_grid_pkg.sv
  - logic/snake_bus_pkg.sv
  - logic/scene_if.sv
  - logic/update_queue_if.sv
  - logic/cell_classifier.sv
  - logic/frame_tracker.sv
  - logic/update_fifo.sv
  - logic/apb_game_regs.sv
  - logic/snake_display_top.sv
  - target: test
    files:
      - test/snake_display_assert.sv
      - test/snake_display_checker.sv
      - test/tb_snake_display.sv
